// ==== common/ddr_pkg.sv ====
package ddr_pkg;

    // memory side geometry
    localparam int ADDR_W = 49;
    localparam int DATA_W = 128;
    localparam int LEN_W  = 8;

    // client command word
    localparam int CMD_W        = 64;
    localparam int CMD_ADDR_LSB = 0;
    localparam int CMD_LEN_LSB  = 49;

    localparam int NUM_WR_CH = 2;
    // write id carries the channel number
    localparam int WID_W = (NUM_WR_CH > 1) ? $clog2(NUM_WR_CH) : 1;

    // bursts are capped at this many beats as well
    localparam int FIFO_DEPTH = 16;

    typedef logic [ADDR_W-1:0] ddr_addr_t;
    typedef logic [DATA_W-1:0] ddr_data_t;
    typedef logic [CMD_W-1:0]  ddr_cmd_t;
    typedef logic [LEN_W-1:0]  ddr_len_t;
    typedef logic [WID_W-1:0]  ddr_wid_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_ADDR,
        WR_DATA,
        WR_RESP
    } wr_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

endpackage

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] din,
    input  logic             wr_en,
    output logic             full,
    output logic [WIDTH-1:0] dout,
    input  logic             rd_en,
    output logic             empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push  = wr_en && !full;
    assign pop   = rd_en && !empty;
    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    // show-ahead read, head entry sits on dout
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the producer must watch full, the consumer must watch empty
    a_push_full: assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && full))
        else $error("push into full fifo");
    a_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) !(rd_en && empty))
        else $error("pop from empty fifo");

endmodule

// ==== ddr_chan/ddr_wr_chan.sv ====
`timescale 1ns/1ps

module ddr_wr_chan (
    input  logic               clk,
    input  logic               rst_n,
    input  ddr_pkg::ddr_cmd_t  cmd_din,
    input  logic               cmd_wr_en,
    output logic               cmd_full,
    input  ddr_pkg::ddr_data_t wr_din,
    input  logic               wr_wr_en,
    output logic               wr_full,
    output logic               awvalid,
    input  logic               awready,
    output ddr_pkg::ddr_addr_t awaddr,
    output ddr_pkg::ddr_len_t  awlen,
    output logic               wvalid,
    input  logic               wready,
    output ddr_pkg::ddr_data_t wdata,
    output logic               wlast,
    input  logic               bvalid,
    output logic               bready
);
    import ddr_pkg::*;

    wr_state_t state;
    ddr_cmd_t  cmd_dout;
    logic      cmd_empty;
    logic      cmd_pop;
    logic      wr_empty;
    logic      wr_pop;
    ddr_addr_t addr_q;
    ddr_len_t  len_q;
    ddr_len_t  beat_cnt;

    sync_fifo #(
        .WIDTH (CMD_W),
        .DEPTH (FIFO_DEPTH)
    ) i_cmd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (cmd_din),
        .wr_en (cmd_wr_en),
        .full  (cmd_full),
        .dout  (cmd_dout),
        .rd_en (cmd_pop),
        .empty (cmd_empty)
    );

    sync_fifo #(
        .WIDTH (DATA_W),
        .DEPTH (FIFO_DEPTH)
    ) i_wr_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (wr_din),
        .wr_en (wr_wr_en),
        .full  (wr_full),
        .dout  (wdata),
        .rd_en (wr_pop),
        .empty (wr_empty)
    );

    assign cmd_pop = (state == WR_IDLE) && !cmd_empty;
    assign wr_pop  = wvalid && wready;

    assign awvalid = (state == WR_ADDR);
    assign awaddr  = addr_q;
    assign awlen   = len_q;
    // beats may trail the command, so valid tracks the data fifo
    assign wvalid  = (state == WR_DATA) && !wr_empty;
    assign wlast   = (state == WR_DATA) && (beat_cnt == len_q);
    assign bready  = (state == WR_RESP);

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            addr_q <= cmd_dout[CMD_ADDR_LSB +: ADDR_W];
            len_q  <= cmd_dout[CMD_LEN_LSB +: LEN_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= WR_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (cmd_pop) begin
                        state <= WR_ADDR;
                    end
                end
                WR_ADDR: begin
                    beat_cnt <= '0;
                    if (awready) begin
                        state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wr_pop) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast) begin
                            state <= WR_RESP;
                        end
                    end
                end
                WR_RESP: begin
                    if (bvalid) begin
                        state <= WR_IDLE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // counted final beat stays within the fifo depth
    a_last_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid && wready && wlast |-> int'(beat_cnt) < FIFO_DEPTH)
        else $error("final beat past the burst limit");

endmodule

// ==== ddr_chan/ddr_rd_chan.sv ====
`timescale 1ns/1ps

module ddr_rd_chan (
    input  logic               clk,
    input  logic               rst_n,
    input  ddr_pkg::ddr_cmd_t  cmd_din,
    input  logic               cmd_wr_en,
    output logic               cmd_full,
    output ddr_pkg::ddr_data_t rd_dout,
    input  logic               rd_rd_en,
    output logic               rd_empty,
    output logic               rd_full,
    output logic               arvalid,
    input  logic               arready,
    output ddr_pkg::ddr_addr_t araddr,
    output ddr_pkg::ddr_len_t  arlen,
    input  ddr_pkg::ddr_data_t rdata,
    input  logic               rlast,
    input  logic               rvalid,
    output logic               rready
);
    import ddr_pkg::*;

    rd_state_t state;
    ddr_cmd_t  cmd_dout;
    logic      cmd_empty;
    logic      cmd_pop;
    logic      r_beat;
    ddr_addr_t addr_q;
    ddr_len_t  len_q;

    sync_fifo #(
        .WIDTH (CMD_W),
        .DEPTH (FIFO_DEPTH)
    ) i_cmd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (cmd_din),
        .wr_en (cmd_wr_en),
        .full  (cmd_full),
        .dout  (cmd_dout),
        .rd_en (cmd_pop),
        .empty (cmd_empty)
    );

    // R beats land here, the client drains them
    sync_fifo #(
        .WIDTH (DATA_W),
        .DEPTH (FIFO_DEPTH)
    ) i_rd_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (rdata),
        .wr_en (r_beat),
        .full  (rd_full),
        .dout  (rd_dout),
        .rd_en (rd_rd_en),
        .empty (rd_empty)
    );

    assign cmd_pop = (state == RD_IDLE) && !cmd_empty;
    assign arvalid = (state == RD_ADDR);
    assign araddr  = addr_q;
    assign arlen   = len_q;
    assign rready  = !rd_full;
    assign r_beat  = rvalid && rready;

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            addr_q <= cmd_dout[CMD_ADDR_LSB +: ADDR_W];
            len_q  <= cmd_dout[CMD_LEN_LSB +: LEN_W];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: if (cmd_pop) state <= RD_ADDR;
                RD_ADDR: if (arready) state <= RD_DATA;
                RD_DATA: if (r_beat && rlast) state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    // memory only returns data for the one outstanding AR
    a_r_requested: assert property (@(posedge clk) disable iff (!rst_n)
        r_beat |-> state == RD_DATA)
        else $error("R beat without outstanding read");

endmodule

// ==== rtl/ddr_wr_arbiter.sv ====
`timescale 1ns/1ps

module ddr_wr_arbiter (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic [ddr_pkg::NUM_WR_CH-1:0]                 awvalid,
    output logic [ddr_pkg::NUM_WR_CH-1:0]                 awready,
    input  ddr_pkg::ddr_addr_t [ddr_pkg::NUM_WR_CH-1:0]   awaddr,
    input  ddr_pkg::ddr_len_t [ddr_pkg::NUM_WR_CH-1:0]    awlen,
    input  logic [ddr_pkg::NUM_WR_CH-1:0]                 wvalid,
    output logic [ddr_pkg::NUM_WR_CH-1:0]                 wready,
    input  ddr_pkg::ddr_data_t [ddr_pkg::NUM_WR_CH-1:0]   wdata,
    input  logic [ddr_pkg::NUM_WR_CH-1:0]                 wlast,
    output logic [ddr_pkg::NUM_WR_CH-1:0]                 bvalid,
    input  logic [ddr_pkg::NUM_WR_CH-1:0]                 bready,
    output ddr_pkg::ddr_addr_t                            m_axi_awaddr,
    output ddr_pkg::ddr_len_t                             m_axi_awlen,
    output ddr_pkg::ddr_wid_t                             m_axi_awid,
    output logic                                          m_axi_awvalid,
    input  logic                                          m_axi_awready,
    output ddr_pkg::ddr_data_t                            m_axi_wdata,
    output logic                                          m_axi_wlast,
    output logic                                          m_axi_wvalid,
    input  logic                                          m_axi_wready,
    input  ddr_pkg::ddr_wid_t                             m_axi_bid,
    input  logic                                          m_axi_bvalid,
    output logic                                          m_axi_bready
);
    import ddr_pkg::*;

    logic     busy;
    logic     req_any;
    logic     b_done;
    ddr_wid_t grant_q;
    ddr_wid_t last_q;
    ddr_wid_t pick;

    assign b_done = m_axi_bvalid && m_axi_bready;

    // next requester after the last one served
    always_comb begin
        int idx;
        idx     = 0;
        req_any = 1'b0;
        pick    = last_q;
        for (int off = 1; off <= NUM_WR_CH; off++) begin
            idx = (int'(last_q) + off) % NUM_WR_CH;
            if (!req_any && awvalid[idx]) begin
                req_any = 1'b1;
                pick    = ddr_wid_t'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            grant_q <= '0;
            last_q  <= ddr_wid_t'(NUM_WR_CH - 1);
        end else if (!busy) begin
            if (req_any) begin
                busy    <= 1'b1;
                grant_q <= pick;
            end
        end else if (b_done) begin
            busy   <= 1'b0;
            last_q <= grant_q;
        end
    end

    assign m_axi_awvalid = busy && awvalid[grant_q];
    assign m_axi_awaddr  = awaddr[grant_q];
    assign m_axi_awlen   = awlen[grant_q];
    assign m_axi_awid    = grant_q;
    assign m_axi_wvalid  = busy && wvalid[grant_q];
    assign m_axi_wdata   = wdata[grant_q];
    assign m_axi_wlast   = wlast[grant_q];
    assign m_axi_bready  = busy && bready[grant_q];

    // ready and response only reach the granted channel
    always_comb begin
        for (int i = 0; i < NUM_WR_CH; i++) begin
            awready[i] = busy && (int'(grant_q) == i) && m_axi_awready;
            wready[i]  = busy && (int'(grant_q) == i) && m_axi_wready;
            bvalid[i]  = busy && (int'(grant_q) == i) && m_axi_bvalid;
        end
    end

    a_bid_match: assert property (@(posedge clk) disable iff (!rst_n)
        b_done |-> m_axi_bid == grant_q)
        else $error("bid does not match granted channel");

    // AW payload holds while the memory stalls it
    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        m_axi_awvalid && !m_axi_awready |=> m_axi_awvalid && $stable(m_axi_awid)
            && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
        else $error("AW payload changed before awready");

endmodule

// ==== rtl/ps_ddr_top.sv ====
`timescale 1ns/1ps

module ps_ddr_top (
    input  logic               clk,
    input  logic               rst_n,
    input  ddr_pkg::ddr_cmd_t  cmd_din_ch0,
    input  logic               cmd_wr_en_ch0,
    output logic               cmd_full_ch0,
    input  ddr_pkg::ddr_data_t wr_din_ch0,
    input  logic               wr_wr_en_ch0,
    output logic               wr_full_ch0,
    input  ddr_pkg::ddr_cmd_t  cmd_din_ch1,
    input  logic               cmd_wr_en_ch1,
    output logic               cmd_full_ch1,
    input  ddr_pkg::ddr_data_t wr_din_ch1,
    input  logic               wr_wr_en_ch1,
    output logic               wr_full_ch1,
    input  ddr_pkg::ddr_cmd_t  cmd_din_rd,
    input  logic               cmd_wr_en_rd,
    output logic               cmd_full_rd,
    output ddr_pkg::ddr_data_t rd_dout,
    input  logic               rd_rd_en,
    output logic               rd_empty,
    output logic               rd_full,
    output ddr_pkg::ddr_addr_t m_axi_awaddr,
    output ddr_pkg::ddr_len_t  m_axi_awlen,
    output ddr_pkg::ddr_wid_t  m_axi_awid,
    output logic               m_axi_awvalid,
    input  logic               m_axi_awready,
    output ddr_pkg::ddr_data_t m_axi_wdata,
    output logic               m_axi_wlast,
    output logic               m_axi_wvalid,
    input  logic               m_axi_wready,
    input  ddr_pkg::ddr_wid_t  m_axi_bid,
    input  logic               m_axi_bvalid,
    output logic               m_axi_bready,
    output ddr_pkg::ddr_addr_t m_axi_araddr,
    output ddr_pkg::ddr_len_t  m_axi_arlen,
    output logic               m_axi_arvalid,
    input  logic               m_axi_arready,
    input  ddr_pkg::ddr_data_t m_axi_rdata,
    input  logic               m_axi_rlast,
    input  logic               m_axi_rvalid,
    output logic               m_axi_rready
);
    import ddr_pkg::*;

    ddr_cmd_t [NUM_WR_CH-1:0]  ch_cmd_din;
    ddr_data_t [NUM_WR_CH-1:0] ch_wr_din;
    ddr_addr_t [NUM_WR_CH-1:0] ch_awaddr;
    ddr_len_t [NUM_WR_CH-1:0]  ch_awlen;
    ddr_data_t [NUM_WR_CH-1:0] ch_wdata;
    logic [NUM_WR_CH-1:0]      ch_cmd_wr_en;
    logic [NUM_WR_CH-1:0]      ch_cmd_full;
    logic [NUM_WR_CH-1:0]      ch_wr_wr_en;
    logic [NUM_WR_CH-1:0]      ch_wr_full;
    logic [NUM_WR_CH-1:0]      ch_awvalid;
    logic [NUM_WR_CH-1:0]      ch_awready;
    logic [NUM_WR_CH-1:0]      ch_wvalid;
    logic [NUM_WR_CH-1:0]      ch_wready;
    logic [NUM_WR_CH-1:0]      ch_wlast;
    logic [NUM_WR_CH-1:0]      ch_bvalid;
    logic [NUM_WR_CH-1:0]      ch_bready;

    // client ports into per-channel arrays
    assign ch_cmd_din   = {cmd_din_ch1, cmd_din_ch0};
    assign ch_cmd_wr_en = {cmd_wr_en_ch1, cmd_wr_en_ch0};
    assign ch_wr_din    = {wr_din_ch1, wr_din_ch0};
    assign ch_wr_wr_en  = {wr_wr_en_ch1, wr_wr_en_ch0};
    assign {cmd_full_ch1, cmd_full_ch0} = ch_cmd_full;
    assign {wr_full_ch1, wr_full_ch0}   = ch_wr_full;

    for (genvar n = 0; n < NUM_WR_CH; n++) begin : g_wr_chan
        ddr_wr_chan i_wr_chan (
            .clk       (clk),
            .rst_n     (rst_n),
            .cmd_din   (ch_cmd_din[n]),
            .cmd_wr_en (ch_cmd_wr_en[n]),
            .cmd_full  (ch_cmd_full[n]),
            .wr_din    (ch_wr_din[n]),
            .wr_wr_en  (ch_wr_wr_en[n]),
            .wr_full   (ch_wr_full[n]),
            .awvalid   (ch_awvalid[n]),
            .awready   (ch_awready[n]),
            .awaddr    (ch_awaddr[n]),
            .awlen     (ch_awlen[n]),
            .wvalid    (ch_wvalid[n]),
            .wready    (ch_wready[n]),
            .wdata     (ch_wdata[n]),
            .wlast     (ch_wlast[n]),
            .bvalid    (ch_bvalid[n]),
            .bready    (ch_bready[n])
        );
    end

    ddr_wr_arbiter i_wr_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .awvalid       (ch_awvalid),
        .awready       (ch_awready),
        .awaddr        (ch_awaddr),
        .awlen         (ch_awlen),
        .wvalid        (ch_wvalid),
        .wready        (ch_wready),
        .wdata         (ch_wdata),
        .wlast         (ch_wlast),
        .bvalid        (ch_bvalid),
        .bready        (ch_bready),
        .m_axi_awaddr  (m_axi_awaddr),
        .m_axi_awlen   (m_axi_awlen),
        .m_axi_awid    (m_axi_awid),
        .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready),
        .m_axi_wdata   (m_axi_wdata),
        .m_axi_wlast   (m_axi_wlast),
        .m_axi_wvalid  (m_axi_wvalid),
        .m_axi_wready  (m_axi_wready),
        .m_axi_bid     (m_axi_bid),
        .m_axi_bvalid  (m_axi_bvalid),
        .m_axi_bready  (m_axi_bready)
    );

    // single reader goes straight to AR/R
    ddr_rd_chan i_rd_chan (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_din   (cmd_din_rd),
        .cmd_wr_en (cmd_wr_en_rd),
        .cmd_full  (cmd_full_rd),
        .rd_dout   (rd_dout),
        .rd_rd_en  (rd_rd_en),
        .rd_empty  (rd_empty),
        .rd_full   (rd_full),
        .arvalid   (m_axi_arvalid),
        .arready   (m_axi_arready),
        .araddr    (m_axi_araddr),
        .arlen     (m_axi_arlen),
        .rdata     (m_axi_rdata),
        .rlast     (m_axi_rlast),
        .rvalid    (m_axi_rvalid),
        .rready    (m_axi_rready)
    );

endmodule

// ==== tb/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model (
    input  logic               clk,
    input  logic               rst_n,
    input  ddr_pkg::ddr_addr_t awaddr,
    input  ddr_pkg::ddr_len_t  awlen,
    input  ddr_pkg::ddr_wid_t  awid,
    input  logic               awvalid,
    output logic               awready,
    input  ddr_pkg::ddr_data_t wdata,
    input  logic               wlast,
    input  logic               wvalid,
    output logic               wready,
    output ddr_pkg::ddr_wid_t  bid,
    output logic               bvalid,
    input  logic               bready,
    input  ddr_pkg::ddr_addr_t araddr,
    input  ddr_pkg::ddr_len_t  arlen,
    input  logic               arvalid,
    output logic               arready,
    output ddr_pkg::ddr_data_t rdata,
    output logic               rlast,
    output logic               rvalid,
    input  logic               rready
);
    import ddr_pkg::*;

    localparam logic [31:0] LCG_SEED = 32'd31771;

    // 256 beats of 16 bytes, address bits 11:4 pick the beat
    ddr_data_t   mem [256];
    ddr_wid_t    id_mem [256];
    ddr_wid_t    aw_log [64];
    ddr_len_t    len_log [64];
    logic [6:0]  aw_cnt;
    logic [31:0] lcg;
    logic        w_active;
    logic [7:0]  w_idx;
    ddr_wid_t    w_id;
    logic        r_active;
    logic [7:0]  r_idx;
    ddr_len_t    r_left;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lcg      <= LCG_SEED;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bid      <= '0;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rlast    <= 1'b0;
            rdata    <= '0;
            aw_cnt   <= '0;
            w_active <= 1'b0;
            w_idx    <= '0;
            w_id     <= '0;
            r_active <= 1'b0;
            r_idx    <= '0;
            r_left   <= '0;
        end else begin
            lcg <= lcg_next(lcg);
            // one write burst at a time, id and length logged in AW order
            if (awvalid && awready) begin
                awready  <= 1'b0;
                w_active <= 1'b1;
                w_idx    <= awaddr[11:4];
                w_id     <= awid;
                if (aw_cnt < 7'd64) begin
                    aw_log[aw_cnt[5:0]]  <= awid;
                    len_log[aw_cnt[5:0]] <= awlen;
                end
                aw_cnt <= aw_cnt + 1'b1;
            end else begin
                awready <= !w_active && !bvalid && lcg[16];
            end
            if (wvalid && wready) begin
                mem[w_idx]    <= wdata;
                id_mem[w_idx] <= w_id;
                w_idx         <= w_idx + 1'b1;
            end
            if (wvalid && wready && wlast) begin
                wready   <= 1'b0;
                w_active <= 1'b0;
                bvalid   <= 1'b1;
                bid      <= w_id;
            end else begin
                wready <= w_active && (lcg[17] || lcg[18]);
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (arvalid && arready) begin
                arready  <= 1'b0;
                r_active <= 1'b1;
                r_idx    <= araddr[11:4];
                r_left   <= arlen;
            end else begin
                arready <= !r_active && lcg[19];
            end
            // beat is held until the channel takes it
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_idx  <= r_idx + 1'b1;
                r_left <= r_left - 1'b1;
                if (rlast) begin
                    r_active <= 1'b0;
                end
            end else if (r_active && !rvalid && lcg[20]) begin
                rvalid <= 1'b1;
                rdata  <= mem[r_idx];
                rlast  <= (r_left == '0);
            end
        end
    end

endmodule

// ==== tb/tb_ps_ddr_top.sv ====
`timescale 1ns/1ps

module tb_ps_ddr_top;
    import ddr_pkg::*;

    // five tests at roughly 800 cycles each
    localparam int MAX_CYCLES = 4000;

    logic      clk = 1'b0;
    logic      rst_n;
    ddr_cmd_t  cmd_din_ch0;
    logic      cmd_wr_en_ch0;
    logic      cmd_full_ch0;
    ddr_data_t wr_din_ch0;
    logic      wr_wr_en_ch0;
    logic      wr_full_ch0;
    ddr_cmd_t  cmd_din_ch1;
    logic      cmd_wr_en_ch1;
    logic      cmd_full_ch1;
    ddr_data_t wr_din_ch1;
    logic      wr_wr_en_ch1;
    logic      wr_full_ch1;
    ddr_cmd_t  cmd_din_rd;
    logic      cmd_wr_en_rd;
    logic      cmd_full_rd;
    ddr_data_t rd_dout;
    logic      rd_rd_en;
    logic      rd_empty;
    logic      rd_full;
    ddr_addr_t m_axi_awaddr;
    ddr_len_t  m_axi_awlen;
    ddr_wid_t  m_axi_awid;
    logic      m_axi_awvalid;
    logic      m_axi_awready;
    ddr_data_t m_axi_wdata;
    logic      m_axi_wlast;
    logic      m_axi_wvalid;
    logic      m_axi_wready;
    ddr_wid_t  m_axi_bid;
    logic      m_axi_bvalid;
    logic      m_axi_bready;
    ddr_addr_t m_axi_araddr;
    ddr_len_t  m_axi_arlen;
    logic      m_axi_arvalid;
    logic      m_axi_arready;
    ddr_data_t m_axi_rdata;
    logic      m_axi_rlast;
    logic      m_axi_rvalid;
    logic      m_axi_rready;

    int n_checks = 0;
    int n_errors = 0;
    int cycles = 0;
    int b_cnt = 0;
    int r_beats = 0;
    int rlast_at = 0;

    always #4 clk = ~clk;

    ps_ddr_top i_ps_ddr_top (.*);

    axi_mem_model i_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (m_axi_awaddr),
        .awlen   (m_axi_awlen),
        .awid    (m_axi_awid),
        .awvalid (m_axi_awvalid),
        .awready (m_axi_awready),
        .wdata   (m_axi_wdata),
        .wlast   (m_axi_wlast),
        .wvalid  (m_axi_wvalid),
        .wready  (m_axi_wready),
        .bid     (m_axi_bid),
        .bvalid  (m_axi_bvalid),
        .bready  (m_axi_bready),
        .araddr  (m_axi_araddr),
        .arlen   (m_axi_arlen),
        .arvalid (m_axi_arvalid),
        .arready (m_axi_arready),
        .rdata   (m_axi_rdata),
        .rlast   (m_axi_rlast),
        .rvalid  (m_axi_rvalid),
        .rready  (m_axi_rready)
    );

    // cycle limit, B count and position of rlast within the burst
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (m_axi_bvalid && m_axi_bready) begin
            b_cnt = b_cnt + 1;
        end
        if (m_axi_rvalid && m_axi_rready) begin
            if (m_axi_rlast) begin
                rlast_at = r_beats + 1;
                r_beats  = 0;
            end else begin
                r_beats = r_beats + 1;
            end
        end
        if (cycles > MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    // beat pattern: tag, channel, beat index, byte address and its inverse
    function automatic ddr_data_t ref_beat(input int ch, input ddr_addr_t addr, input int idx);
        logic [31:0] a;
        a = addr[31:0] + 32'(idx * 16);
        return {8'hA5, 8'(ch), 16'(idx), a, ~a, a ^ 32'h5A5A_0000 ^ 32'(ch << 8)};
    endfunction

    task automatic check_val(input ddr_data_t got, input ddr_data_t exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s finished with %0d errors", num, name, n_errors - errs_before);
    endtask

    task automatic push_beats(input int ch, input ddr_addr_t addr, input int beats);
        for (int i = 0; i < beats; i++) begin
            @(posedge clk);
            #1;
            if (ch == 0) begin
                wr_din_ch0   = ref_beat(0, addr, i);
                wr_wr_en_ch0 = 1'b1;
            end else begin
                wr_din_ch1   = ref_beat(1, addr, i);
                wr_wr_en_ch1 = 1'b1;
            end
        end
        @(posedge clk);
        #1;
        if (ch == 0) begin
            wr_wr_en_ch0 = 1'b0;
        end else begin
            wr_wr_en_ch1 = 1'b0;
        end
    endtask

    // ch 2 is the read channel
    task automatic push_cmd(input int ch, input ddr_addr_t addr, input int beats);
        ddr_cmd_t cmd;
        cmd = '0;
        cmd[CMD_ADDR_LSB +: ADDR_W] = addr;
        cmd[CMD_LEN_LSB +: LEN_W]   = LEN_W'(beats - 1);
        @(posedge clk);
        #1;
        case (ch)
            0: begin
                cmd_din_ch0   = cmd;
                cmd_wr_en_ch0 = 1'b1;
            end
            1: begin
                cmd_din_ch1   = cmd;
                cmd_wr_en_ch1 = 1'b1;
            end
            default: begin
                cmd_din_rd   = cmd;
                cmd_wr_en_rd = 1'b1;
            end
        endcase
        @(posedge clk);
        #1;
        case (ch)
            0:       cmd_wr_en_ch0 = 1'b0;
            1:       cmd_wr_en_ch1 = 1'b0;
            default: cmd_wr_en_rd  = 1'b0;
        endcase
    endtask

    task automatic wait_writes(input int target);
        while (b_cnt < target) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain_read(input int ch, input ddr_addr_t addr, input int beats,
                              input string what);
        int i;
        i = 0;
        while (i < beats) begin
            @(posedge clk);
            #1;
            rd_rd_en = 1'b0;
            if (!rd_empty) begin
                check_val(rd_dout, ref_beat(ch, addr, i), what);
                rd_rd_en = 1'b1;
                i++;
            end
        end
        @(posedge clk);
        #1;
        rd_rd_en = 1'b0;
        check_val(DATA_W'(rlast_at), DATA_W'(beats), "beat carrying rlast");
    endtask

    task automatic check_ids(input int ch, input ddr_addr_t addr, input int beats);
        logic [7:0] idx;
        for (int i = 0; i < beats; i++) begin
            idx = addr[11:4] + 8'(i);
            check_val(DATA_W'(i_mem.id_mem[idx]), DATA_W'(ch), "awid recorded for region");
        end
    endtask

    initial begin
        int errs;
        int start;
        int exp_id;
        rst_n         = 1'b0;
        cmd_din_ch0   = '0;
        cmd_wr_en_ch0 = 1'b0;
        wr_din_ch0    = '0;
        wr_wr_en_ch0  = 1'b0;
        cmd_din_ch1   = '0;
        cmd_wr_en_ch1 = 1'b0;
        wr_din_ch1    = '0;
        wr_wr_en_ch1  = 1'b0;
        cmd_din_rd    = '0;
        cmd_wr_en_rd  = 1'b0;
        rd_rd_en      = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        errs = n_errors;
        check_val(DATA_W'(m_axi_awvalid), '0, "awvalid after reset");
        check_val(DATA_W'(m_axi_wvalid), '0, "wvalid after reset");
        check_val(DATA_W'(m_axi_arvalid), '0, "arvalid after reset");
        check_val(DATA_W'(m_axi_bready), '0, "bready after reset");
        check_val(DATA_W'(rd_empty), DATA_W'(1), "rd_empty after reset");
        check_val(DATA_W'(cmd_full_ch0), '0, "cmd_full_ch0 after reset");
        check_val(DATA_W'(cmd_full_ch1), '0, "cmd_full_ch1 after reset");
        check_val(DATA_W'(cmd_full_rd), '0, "cmd_full_rd after reset");
        check_val(DATA_W'(wr_full_ch0), '0, "wr_full_ch0 after reset");
        check_val(DATA_W'(wr_full_ch1), '0, "wr_full_ch1 after reset");
        report_test(1, "reset state", errs);

        errs = n_errors;
        push_beats(0, ADDR_W'(32'h000), 4);
        push_cmd(0, ADDR_W'(32'h000), 4);
        wait_writes(1);
        push_cmd(2, ADDR_W'(32'h000), 4);
        drain_read(0, ADDR_W'(32'h000), 4, "single burst readback");
        report_test(2, "write then read", errs);

        // both channels load at once
        errs = n_errors;
        fork
            begin
                push_beats(0, ADDR_W'(32'h100), 8);
                push_cmd(0, ADDR_W'(32'h100), 8);
            end
            begin
                push_beats(1, ADDR_W'(32'h200), 8);
                push_cmd(1, ADDR_W'(32'h200), 8);
            end
        join
        wait_writes(3);
        check_ids(0, ADDR_W'(32'h100), 8);
        check_ids(1, ADDR_W'(32'h200), 8);
        push_cmd(2, ADDR_W'(32'h100), 8);
        drain_read(0, ADDR_W'(32'h100), 8, "channel 0 region readback");
        push_cmd(2, ADDR_W'(32'h200), 8);
        drain_read(1, ADDR_W'(32'h200), 8, "channel 1 region readback");
        report_test(3, "two channel writes", errs);

        errs = n_errors;
        push_beats(0, ADDR_W'(32'h400), 16);
        // no command yet, so all 16 beats sit in the data fifo
        check_val(DATA_W'(wr_full_ch0), DATA_W'(1), "wr_full_ch0 with 16 beats queued");
        push_cmd(0, ADDR_W'(32'h400), 16);
        wait_writes(4);
        push_cmd(2, ADDR_W'(32'h400), 16);
        while (!rd_full) begin
            @(posedge clk);
            #1;
        end
        check_val(DATA_W'(m_axi_rready), '0, "rready while read fifo full");
        drain_read(0, ADDR_W'(32'h400), 16, "stalled read readback");
        report_test(4, "read back-pressure", errs);

        errs = n_errors;
        start = int'(i_mem.aw_cnt);
        fork
            begin
                for (int k = 0; k < 3; k++) push_beats(0, ADDR_W'(32'h600 + k * 64), 4);
                for (int k = 0; k < 3; k++) push_cmd(0, ADDR_W'(32'h600 + k * 64), 4);
            end
            begin
                for (int k = 0; k < 3; k++) push_beats(1, ADDR_W'(32'h800 + k * 64), 4);
                for (int k = 0; k < 3; k++) push_cmd(1, ADDR_W'(32'h800 + k * 64), 4);
            end
        join
        wait_writes(10);
        check_val(DATA_W'(int'(i_mem.aw_cnt) - start), DATA_W'(6), "bursts seen in test 5");
        // test 4 ended on channel 0, so channel 1 goes first
        exp_id = 1;
        for (int k = 0; k < 6; k++) begin
            check_val(DATA_W'(i_mem.aw_log[6'(start + k)]), DATA_W'(exp_id), "awid order");
            check_val(DATA_W'(i_mem.len_log[6'(start + k)]), DATA_W'(3), "awlen of 4-beat burst");
            exp_id = (exp_id + 1) % NUM_WR_CH;
        end
        report_test(5, "round-robin order", errs);

        $display("tests run 5, checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
common/ddr_pkg.sv
rtl/sync_fifo.sv
ddr_chan/ddr_wr_chan.sv
ddr_chan/ddr_rd_chan.sv
rtl/ddr_wr_arbiter.sv
rtl/ps_ddr_top.sv
tb/axi_mem_model.sv
tb/tb_ps_ddr_top.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_ps_ddr_top -f tb.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -x '>>> PASS' > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
